// ==== tb.f ====
logic/stream_cfg_pkg.sv
logic/mem_port_pkg.sv
logic/source_addrgen.sv
logic/source_req_issue.sv
logic/source_rsp_buffer.sv
logic/source_merge.sv
logic/stream_source.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f

BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_top.sv ====
// stream_source with NB_PORTS = 2, word at byte address A is ~A
// grants and stream ready stall at random per row, LFSR seeded 32'hcdf7e166

module tb_top;

  localparam int unsigned NB_PORTS  = 2;
  localparam int          NUM_TESTS = 7;

  typedef struct packed {
    logic [95:0]           name;
    stream_cfg_pkg::addr_t base;
    stream_cfg_pkg::len_t  len;
    logic                  gnt_stall;
    logic                  rdy_stall;
    stream_cfg_pkg::len_t  exp_beats;
  } test_row_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  stream_cfg_pkg::ctrl_t                 ctrl;
  stream_cfg_pkg::flags_t                flags;
  mem_port_pkg::mem_req_t [NB_PORTS-1:0] mem_req;
  mem_port_pkg::mem_rsp_t [NB_PORTS-1:0] mem_rsp;
  stream_cfg_pkg::word_t  [NB_PORTS-1:0] stream_data;
  logic                                  stream_valid;
  logic                                  stream_ready;

  test_row_t             cur_row;
  logic [31:0]           lfsr_q;
  logic [NB_PORTS-1:0]   pend_q;  // reply due after the next rising edge
  stream_cfg_pkg::addr_t pend_addr_q [NB_PORTS];
  logic                  gnt_stall_q;
  logic                  rdy_stall_q;
  int                    error_count;
  int                    tests_done;

  always #20 clk_i = ~clk_i;

  function automatic test_row_t test_row(input int idx);
    case (idx)
      0:       return '{"plain",     32'h0000_1000, 16'd8,  1'b0, 1'b0, 16'd8};
      1:       return '{"gnt_rand",  32'h0000_2040, 16'd12, 1'b1, 1'b0, 16'd12};
      2:       return '{"rdy_rand",  32'h0001_0008, 16'd12, 1'b0, 1'b1, 16'd12};
      3:       return '{"both_rand", 32'h8000_0100, 16'd16, 1'b1, 1'b1, 16'd16};
      4:       return '{"single",    32'h0000_0ff8, 16'd1,  1'b0, 1'b0, 16'd1};
      5:       return '{"wrap",      32'hffff_ffe0, 16'd6,  1'b1, 1'b1, 16'd6};
      default: return '{"single_st", 32'h1234_5670, 16'd1,  1'b1, 1'b1, 16'd1};
    endcase
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

  task automatic draw_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  // memory side: capture accepted requests, stall flags latched away from the drive edge
  always @(negedge clk_i) begin
    for (int k = 0; k < NB_PORTS; k++) begin
      pend_q[k]      = rst_ni & mem_req[k].req & mem_rsp[k].gnt;
      pend_addr_q[k] = mem_req[k].addr;
    end
    gnt_stall_q = cur_row.gnt_stall;
    rdy_stall_q = cur_row.rdy_stall;
  end

  always @(posedge clk_i) begin : drive_ports
    logic b;
    #2;
    for (int k = 0; k < NB_PORTS; k++) begin
      b = 1'b1;
      if (gnt_stall_q) draw_bit(b);
      mem_rsp[k].gnt     = b;
      mem_rsp[k].r_valid = pend_q[k];
      mem_rsp[k].r_data  = ~pend_addr_q[k];
    end
    b = 1'b1;
    if (rdy_stall_q) draw_bit(b);
    stream_ready = b;
  end

  stream_source #(.NB_PORTS(NB_PORTS)) dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_i         (ctrl),
    .flags_o        (flags),
    .mem_req_o      (mem_req),
    .mem_rsp_i      (mem_rsp),
    .stream_data_o  (stream_data),
    .stream_valid_o (stream_valid),
    .stream_ready_i (stream_ready)
  );

  tb_checker #(.NB_PORTS(NB_PORTS)) u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_i         (ctrl),
    .flags_i        (flags),
    .stream_data_i  (stream_data),
    .stream_valid_i (stream_valid),
    .stream_ready_i (stream_ready),
    .test_name_i    (cur_row.name),
    .exp_beats_i    (cur_row.exp_beats),
    .error_count_o  (error_count),
    .tests_done_o   (tests_done)
  );

  initial begin : watchdog
    test_row_t row;
    int        budget;
    budget = 16 + 300;  // reset plus margin
    for (int i = 0; i < NUM_TESTS; i++) begin
      row    = test_row(i);
      budget = budget + int'(row.len) * 50;
    end
    repeat (budget) @(posedge clk_i);
    $display("timeout: transfers still running after %0d cycles", budget);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst_ni       = 1'b0;
    ctrl         = '0;
    mem_rsp      = '0;
    stream_ready = 1'b0;
    cur_row      = '0;
    pend_q       = '0;
    lfsr_q       = 32'hcdf7e166;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      cur_row = test_row(i);
      while (!flags.ready_start) begin
        @(posedge clk_i);
        #2;
      end
      ctrl.base_addr  = cur_row.base;
      ctrl.trans_size = cur_row.len;
      ctrl.req_start  = 1'b1;
      @(posedge clk_i);
      #2;
      ctrl.req_start = 1'b0;
      while (!flags.done) begin
        @(posedge clk_i);
        #2;
      end
    end
    repeat (20) @(posedge clk_i);  // no beat may follow the last done
    $display("tests finished: %0d of %0d, errors: %0d", tests_done, NUM_TESTS, error_count);
    if (error_count == 0 && tests_done == NUM_TESTS) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_checker.sv ====
// watches the stream side of the DUT and predicts each beat from the start request
// word k of beat i is ~(base + i*NB_PORTS*4 + 4k)

module tb_checker #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  stream_cfg_pkg::ctrl_t                ctrl_i,
  input  stream_cfg_pkg::flags_t               flags_i,
  input  stream_cfg_pkg::word_t [NB_PORTS-1:0] stream_data_i,
  input  logic                                 stream_valid_i,
  input  logic                                 stream_ready_i,
  input  logic                  [95:0]         test_name_i,
  input  stream_cfg_pkg::len_t                 exp_beats_i,
  output int                                   error_count_o,
  output int                                   tests_done_o
);

  stream_cfg_pkg::addr_t                base_q;
  stream_cfg_pkg::word_t [NB_PORTS-1:0] hold_data_q;
  logic                  [95:0]         name_q;
  int                                   exp_q;
  int                                   beat_q;
  int                                   test_err_q;
  logic                                 active_q;
  logic                                 hold_q;  // valid seen without ready

  task automatic count_error();
    error_count_o = error_count_o + 1;
    test_err_q    = test_err_q + 1;
  endtask

  // outputs are stable by the falling edge
  always @(negedge clk_i) begin : watch
    stream_cfg_pkg::word_t exp_word;
    if (!rst_ni) begin
      error_count_o = 0;
      tests_done_o  = 0;
      test_err_q    = 0;
      beat_q        = 0;
      active_q      = 1'b0;
      hold_q        = 1'b0;
      name_q        = "reset";
    end else begin
      if (hold_q && (!stream_valid_i || stream_data_i != hold_data_q)) begin
        $display("%s: valid dropped or data changed before the handshake", name_q);
        count_error();
      end
      hold_q      = stream_valid_i & ~stream_ready_i;
      hold_data_q = stream_data_i;
      if (stream_valid_i && stream_ready_i) begin
        if (!active_q) begin
          $display("%s: beat accepted while no transfer was open", name_q);
          count_error();
        end else begin
          for (int k = 0; k < NB_PORTS; k++) begin
            exp_word = ~(base_q + stream_cfg_pkg::addr_t'(beat_q * NB_PORTS * 4 + k * 4));
            if (stream_data_i[k] !== exp_word) begin
              $display("[ERROR] %s beat %0d word %0d: expected %h, actual %h",
                       name_q, beat_q, k, exp_word, stream_data_i[k]);
              count_error();
            end
          end
          beat_q = beat_q + 1;
        end
      end
      if (flags_i.done) begin
        if (!active_q) begin
          $display("%s: done pulse with no transfer open", name_q);
          count_error();
        end else begin
          if (beat_q != exp_q) begin
            $display("[ERROR] %s beat count: expected %0d, actual %0d", name_q, exp_q, beat_q);
            count_error();
          end
          if (!flags_i.ready_start) begin
            $display("%s: ready_start is low in the done cycle", name_q);
            count_error();
          end
          $display("%s: %0d beats, %0d errors", name_q, beat_q, test_err_q);
          tests_done_o = tests_done_o + 1;
          active_q     = 1'b0;
        end
      end
      // source is busy from the start until its done
      if (active_q && flags_i.ready_start) begin
        $display("%s: ready_start is high before the done of this transfer", name_q);
        count_error();
      end
      if (ctrl_i.req_start && flags_i.ready_start) begin
        active_q   = 1'b1;
        base_q     = ctrl_i.base_addr;
        exp_q      = int'(exp_beats_i);
        name_q     = test_name_i;
        beat_q     = 0;
        test_err_q = 0;
      end
    end
  end

endmodule

// ==== logic/stream_source.sv ====
// memory-to-stream source over NB_PORTS word-interleaved 32-bit ports
// base address aligned to NB_PORTS*4 bytes, trans_size at least 1

module stream_source #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  stream_cfg_pkg::ctrl_t                 ctrl_i,
  output stream_cfg_pkg::flags_t                flags_o,
  output mem_port_pkg::mem_req_t [NB_PORTS-1:0] mem_req_o,
  input  mem_port_pkg::mem_rsp_t [NB_PORTS-1:0] mem_rsp_i,
  output stream_cfg_pkg::word_t  [NB_PORTS-1:0] stream_data_o,
  output logic                                  stream_valid_o,
  input  logic                                  stream_ready_i
);

  stream_cfg_pkg::addr_t                addr;
  stream_cfg_pkg::word_t [NB_PORTS-1:0] buf_data;
  logic                  [NB_PORTS-1:0] buf_valid;
  logic                  [NB_PORTS-1:0] accept;
  logic                  [NB_PORTS-1:0] granted;
  logic                  [NB_PORTS-1:0] gnt;
  logic                                 addr_valid;
  logic                                 addr_ready;
  logic                                 buf_ready;
  logic                                 ready_start;
  logic                                 start;
  logic                                 last;
  logic                                 done;

  assign start               = ctrl_i.req_start & ready_start;
  assign flags_o.ready_start = ready_start;
  assign flags_o.done        = done;

  source_addrgen #(.NB_PORTS(NB_PORTS)) u_addrgen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl_i),
    .ready_start_o (ready_start),
    .addr_o        (addr),
    .addr_valid_o  (addr_valid),
    .addr_ready_i  (addr_ready),
    .last_i        (last)
  );

  source_req_issue #(.NB_PORTS(NB_PORTS)) u_req_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .addr_i       (addr),
    .addr_valid_i (addr_valid),
    .addr_ready_o (addr_ready),
    .accept_i     (accept),
    .mem_req_o    (mem_req_o),
    .gnt_i        (gnt),
    .granted_o    (granted)
  );

  for (genvar k = 0; k < NB_PORTS; k++) begin : gen_rsp
    assign gnt[k] = mem_rsp_i[k].gnt;

    source_rsp_buffer u_rsp_buffer (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .rsp_i     (mem_rsp_i[k]),
      .granted_i (granted[k]),
      .data_o    (buf_data[k]),
      .valid_o   (buf_valid[k]),
      .ready_i   (buf_ready),
      .accept_o  (accept[k])
    );
  end

  source_merge #(.NB_PORTS(NB_PORTS)) u_merge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .trans_size_i   (ctrl_i.trans_size),
    .start_i        (start),
    .word_i         (buf_data),
    .word_valid_i   (buf_valid),
    .word_ready_o   (buf_ready),
    .stream_data_o  (stream_data_o),
    .stream_valid_o (stream_valid_o),
    .stream_ready_i (stream_ready_i),
    .last_o         (last),
    .done_o         (done)
  );

endmodule

// ==== logic/source_merge.sv ====
// joins the port heads into one beat, all heads pop together
// counts beats of the transfer latched at start

module source_merge #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  stream_cfg_pkg::len_t                 trans_size_i,
  input  logic                                 start_i,
  input  stream_cfg_pkg::word_t [NB_PORTS-1:0] word_i,
  input  logic                  [NB_PORTS-1:0] word_valid_i,
  output logic                                 word_ready_o,
  output stream_cfg_pkg::word_t [NB_PORTS-1:0] stream_data_o,
  output logic                                 stream_valid_o,
  input  logic                                 stream_ready_i,
  output logic                                 last_o,
  output logic                                 done_o
);

  stream_cfg_pkg::len_t beat_cnt_q;
  stream_cfg_pkg::len_t len_q;
  logic                 done_q;
  logic                 beat_hs;

  assign stream_valid_o = &word_valid_i;  // only complete beats
  assign stream_data_o  = word_i;
  assign beat_hs        = stream_valid_o & stream_ready_i;
  assign word_ready_o   = beat_hs;
  assign last_o         = beat_hs & (beat_cnt_q == len_q - stream_cfg_pkg::len_t'(1));
  assign done_o         = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
      len_q      <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= last_o;  // pulse the cycle after the final beat
      if (start_i) begin
        beat_cnt_q <= '0;
        len_q      <= trans_size_i;
      end else if (beat_hs) begin
        beat_cnt_q <= last_o ? '0 : beat_cnt_q + stream_cfg_pkg::len_t'(1);
      end
    end
  end

endmodule

// ==== logic/source_rsp_buffer.sv ====
// two-entry reply FIFO for one port, no bypass: a reply is readable the cycle after r_valid
// accept_o is the credit, replies never find the FIFO full

module source_rsp_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mem_port_pkg::mem_rsp_t rsp_i,
  input  logic                   granted_i,
  output stream_cfg_pkg::word_t  data_o,
  output logic                   valid_o,
  input  logic                   ready_i,
  output logic                   accept_o
);

  stream_cfg_pkg::word_t mem_q [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       pend_q;  // granted last cycle, reply arrives now
  logic       push;
  logic       pop;

  assign push     = rsp_i.r_valid;
  assign valid_o  = (count_q != 2'd0);
  assign pop      = valid_o & ready_i;
  assign data_o   = mem_q[rd_ptr_q];
  assign accept_o = (count_q + {1'b0, pend_q}) < 2'd2;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
      pend_q   <= 1'b0;
    end else begin
      pend_q <= granted_i;
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= rsp_i.r_data;
  end

endmodule

// ==== logic/source_req_issue.sv ====
// sends one beat address to all ports, port k reads addr + 4k
// the address retires once every port has granted, in any order

module source_req_issue #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  stream_cfg_pkg::addr_t                 addr_i,
  input  logic                                  addr_valid_i,
  output logic                                  addr_ready_o,
  input  logic              [NB_PORTS-1:0]      accept_i,
  output mem_port_pkg::mem_req_t [NB_PORTS-1:0] mem_req_o,
  input  logic              [NB_PORTS-1:0]      gnt_i,
  output logic              [NB_PORTS-1:0]      granted_o
);

  logic [NB_PORTS-1:0] granted_q;  // ports already done with this address
  logic [NB_PORTS-1:0] req;
  logic [NB_PORTS-1:0] hs;
  logic [NB_PORTS-1:0] done_ports;

  for (genvar k = 0; k < NB_PORTS; k++) begin : gen_port
    // no request while the port buffer has no room for the reply
    assign req[k]            = addr_valid_i & ~granted_q[k] & accept_i[k];
    assign mem_req_o[k].req  = req[k];
    assign mem_req_o[k].addr = addr_i + stream_cfg_pkg::addr_t'(4 * k);
  end

  assign hs           = req & gnt_i;
  assign done_ports   = granted_q | hs;
  assign addr_ready_o = &done_ports;
  assign granted_o    = hs;  // one reply due next cycle

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      granted_q <= '0;
    end else if (addr_ready_o) begin
      granted_q <= '0;  // address retired
    end else begin
      granted_q <= done_ports;
    end
  end

endmodule

// ==== logic/source_addrgen.sv ====
// start FSM and address stepper; trans_size must be at least 1
// the base address is taken as is, no realignment is done

module source_addrgen #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  stream_cfg_pkg::ctrl_t ctrl_i,
  output logic                  ready_start_o,
  output stream_cfg_pkg::addr_t addr_o,
  output logic                  addr_valid_o,
  input  logic                  addr_ready_i,
  input  logic                  last_i
);

  localparam stream_cfg_pkg::addr_t STEP = stream_cfg_pkg::addr_t'(NB_PORTS * 4);

  stream_cfg_pkg::src_state_e state_q, state_d;
  stream_cfg_pkg::addr_t      addr_q;
  stream_cfg_pkg::len_t       cnt_q;  // addresses already handed over
  stream_cfg_pkg::len_t       len_q;

  logic start;
  logic addr_hs;
  logic last_addr;

  assign ready_start_o = (state_q == stream_cfg_pkg::SRC_IDLE);
  assign start         = ctrl_i.req_start & ready_start_o;
  assign addr_valid_o  = (state_q == stream_cfg_pkg::SRC_WORKING);
  assign addr_o        = addr_q;
  assign addr_hs       = addr_valid_o & addr_ready_i;
  assign last_addr     = (cnt_q == len_q - stream_cfg_pkg::len_t'(1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      stream_cfg_pkg::SRC_IDLE: begin
        if (start) state_d = stream_cfg_pkg::SRC_WORKING;
      end
      stream_cfg_pkg::SRC_WORKING: begin
        if (addr_hs && last_addr) state_d = stream_cfg_pkg::SRC_DRAIN;
      end
      stream_cfg_pkg::SRC_DRAIN: begin
        if (last_i) state_d = stream_cfg_pkg::SRC_IDLE;  // final beat is out
      end
      default: state_d = stream_cfg_pkg::SRC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= stream_cfg_pkg::SRC_IDLE;
      addr_q  <= '0;
      cnt_q   <= '0;
      len_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start) begin
        addr_q <= ctrl_i.base_addr;
        len_q  <= ctrl_i.trans_size;
        cnt_q  <= '0;
      end else if (addr_hs) begin
        addr_q <= addr_q + STEP;
        cnt_q  <= cnt_q + stream_cfg_pkg::len_t'(1);
      end
    end
  end

endmodule

// ==== logic/mem_port_pkg.sv ====
// one 32-bit memory port, read only
// r_valid/r_data come exactly one cycle after the req & gnt cycle

package mem_port_pkg;

  // request side, a read is implied
  typedef struct packed {
    logic                  req;
    stream_cfg_pkg::addr_t addr;
  } mem_req_t;

  // response side
  typedef struct packed {
    logic                  gnt;
    logic                  r_valid;
    stream_cfg_pkg::word_t r_data;
  } mem_rsp_t;

endpackage

// ==== logic/stream_cfg_pkg.sv ====
// control-side types for the stream source
// base addresses are assumed aligned to NB_PORTS*4 bytes, lengths count wide beats

package stream_cfg_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] word_t;  // one memory word
  typedef logic [15:0] len_t;   // transfer length in beats

  // controller request
  typedef struct packed {
    addr_t base_addr;
    len_t  trans_size;
    logic  req_start;
  } ctrl_t;

  // status back to the controller
  typedef struct packed {
    logic ready_start;
    logic done;
  } flags_t;

  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_WORKING,
    SRC_DRAIN  // all addresses issued, waiting for the last beat
  } src_state_e;

endpackage
